// ==== src/mesh_bridge_params.svh ====
`ifndef MESH_BRIDGE_PARAMS_SVH
`define MESH_BRIDGE_PARAMS_SVH

// processor side widths
`define MB_PADDR_W    32
`define MB_DATA_W     32

// mesh network widths
`define MB_EPA_W      16
`define MB_CORD_W     6
`define MB_REG_ID_W   5

// id width must cover MB_MAX_OUT outstanding transactions
`define MB_MAX_OUT    8
`define MB_ID_W       3

// command header queue
`define MB_FIFO_DEPTH 4

// inbound device windows
`define MB_CFG_BASE   32'h0020_0000
`define MB_CLINT_BASE 32'h0030_0000

`endif

// ==== src/mesh_bridge_pkg.sv ====
`include "mesh_bridge_params.svh"

package mesh_bridge_pkg;

  ////////////////////////////////////////////////////////////
  // processor memory messages
  ////////////////////////////////////////////////////////////
  typedef enum logic [1:0]
  {
    e_uc_rd = 2'b00,
    e_uc_wr = 2'b01
  } mem_msg_type_e;

  typedef enum logic [1:0]
  {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10
  } mem_msg_size_e;

  typedef struct packed
  {
    mem_msg_type_e           msg_type;
    mem_msg_size_e           size;
    logic [`MB_PADDR_W-1:0]  addr;
  } mem_header_t;

  typedef struct packed
  {
    mem_header_t             header;
    logic [`MB_DATA_W-1:0]   data;
  } mem_msg_t;

  // address layout for accesses leaving through the mesh
  typedef struct packed
  {
    logic                    remote;
    logic                    pad;
    logic [`MB_CORD_W-1:0]   y;
    logic [`MB_CORD_W-1:0]   x;
    logic [`MB_EPA_W-1:0]    epa;
    logic [1:0]              low_bits;
  } mc_eva_t;

  ////////////////////////////////////////////////////////////
  // mesh network packets
  ////////////////////////////////////////////////////////////
  typedef enum logic
  {
    e_remote_load  = 1'b0,
    e_remote_store = 1'b1
  } net_op_e;

  typedef struct packed
  {
    net_op_e                 op;
    logic [`MB_REG_ID_W-1:0] reg_id;
    logic [3:0]              mask;
    logic [`MB_DATA_W-1:0]   payload;
    logic [`MB_EPA_W-1:0]    epa;
    logic [`MB_CORD_W-1:0]   src_x;
    logic [`MB_CORD_W-1:0]   src_y;
    logic [`MB_CORD_W-1:0]   dst_x;
    logic [`MB_CORD_W-1:0]   dst_y;
  } net_req_t;

  typedef struct packed
  {
    logic [`MB_REG_ID_W-1:0] reg_id;
    logic                    is_load;
    logic [`MB_DATA_W-1:0]   data;
  } net_ret_t;

  // dev 1 selects the timer block and anything else the config block
  typedef struct packed
  {
    logic                    we;
    logic [3:0]              dev;
    logic [11:0]             addr;
    logic [`MB_DATA_W-1:0]   data;
  } net_in_t;

endpackage

// ==== src/cmd_header_fifo.sv ====
`timescale 1ns/1ps
`include "mesh_bridge_params.svh"

module cmd_header_fifo
  (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  mesh_bridge_pkg::mem_msg_t data_i,
    input  logic                      v_i,
    output logic                      ready_o,
    output mesh_bridge_pkg::mem_msg_t data_o,
    output logic                      v_o,
    input  logic                      yumi_i
  );

  import mesh_bridge_pkg::*;

  localparam int PTR_W = $clog2(`MB_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`MB_FIFO_DEPTH + 1);

  mem_msg_t         mem_q [`MB_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign ready_o = (count_q != CNT_W'(`MB_FIFO_DEPTH));
  assign v_o     = (count_q != '0);
  assign push    = v_i & ready_o;
  assign pop     = yumi_i & v_o;
  assign data_o  = mem_q[rd_ptr_q];

  // depth is a power of two so pointers wrap on their own
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_q[wr_ptr_q] <= data_i;
  end

endmodule

// ==== src/outbound_packet_builder.sv ====
`timescale 1ns/1ps
`include "mesh_bridge_params.svh"

module outbound_packet_builder
  (
    input  mesh_bridge_pkg::mem_header_t cmd_i,
    input  logic [`MB_DATA_W-1:0]        data_i,
    input  logic [`MB_ID_W-1:0]          id_i,
    input  logic [`MB_CORD_W-1:0]        my_x_i,
    input  logic [`MB_CORD_W-1:0]        my_y_i,
    output mesh_bridge_pkg::net_req_t    pkt_o
  );

  import mesh_bridge_pkg::*;

  mc_eva_t    eva;
  logic [3:0] store_mask;

  assign eva = mc_eva_t'(cmd_i.addr);

  ////////////////////////////////////////////////////////////
  // byte enables for partial stores
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    case (cmd_i.size)
      e_size_1: store_mask = 4'b0001 << eva.low_bits;
      e_size_2: store_mask = 4'b0011 << eva.low_bits;
      default:  store_mask = 4'b1111;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // routing and packet fields
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    pkt_o        = '0;
    pkt_o.reg_id = {{(`MB_REG_ID_W - `MB_ID_W){1'b0}}, id_i};
    pkt_o.src_x  = my_x_i;
    pkt_o.src_y  = my_y_i;
    pkt_o.epa    = eva.epa;

    if (eva.remote)
    begin
      pkt_o.dst_x = eva.x;
      pkt_o.dst_y = eva.y;
    end
    else
    begin
      // host tile sits one row up in column zero
      pkt_o.dst_x = '0;
      pkt_o.dst_y = my_y_i - 1'b1;
    end

    if (cmd_i.msg_type == e_uc_wr)
    begin
      pkt_o.op      = e_remote_store;
      pkt_o.mask    = store_mask;
      pkt_o.payload = data_i;
    end
    else
    begin
      // load payload holds the size code above the part select
      pkt_o.op      = e_remote_load;
      pkt_o.mask    = 4'b0000;
      pkt_o.payload = {{(`MB_DATA_W - 4){1'b0}}, 2'(cmd_i.size), eva.low_bits};
    end
  end

endmodule

// ==== src/return_reorder_buffer.sv ====
`timescale 1ns/1ps
`include "mesh_bridge_params.svh"

module return_reorder_buffer
  (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    output logic                         alloc_v_o,
    output logic [`MB_ID_W-1:0]          alloc_id_o,
    input  logic                         alloc_yumi_i,
    input  mesh_bridge_pkg::mem_header_t alloc_hdr_i,
    input  mesh_bridge_pkg::net_ret_t    ret_i,
    input  logic                         ret_v_i,
    output mesh_bridge_pkg::mem_msg_t    resp_o,
    output logic                         resp_v_o,
    input  logic                         resp_yumi_i
  );

  import mesh_bridge_pkg::*;

  logic [`MB_MAX_OUT-1:0] valid_q;
  logic [`MB_MAX_OUT-1:0] done_q;
  mem_header_t            hdr_q  [`MB_MAX_OUT];
  logic [`MB_DATA_W-1:0]  data_q [`MB_MAX_OUT];
  logic [`MB_ID_W-1:0]    alloc_ptr_q;
  logic [`MB_ID_W-1:0]    rel_ptr_q;
  logic [`MB_ID_W-1:0]    ret_id;
  logic                   alloc_fire;
  logic                   resp_fire;

  // next slot is free only once its previous owner was released
  assign alloc_v_o  = ~valid_q[alloc_ptr_q];
  assign alloc_id_o = alloc_ptr_q;
  assign alloc_fire = alloc_yumi_i & alloc_v_o;

  assign ret_id    = ret_i.reg_id[`MB_ID_W-1:0];
  assign resp_v_o  = valid_q[rel_ptr_q] & done_q[rel_ptr_q];
  assign resp_fire = resp_yumi_i & resp_v_o;
  assign resp_o    = '{header: hdr_q[rel_ptr_q], data: data_q[rel_ptr_q]};

  ////////////////////////////////////////////////////////////
  // entry flags and ring pointers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      valid_q     <= '0;
      done_q      <= '0;
      alloc_ptr_q <= '0;
      rel_ptr_q   <= '0;
    end
    else
    begin
      if (alloc_fire)
      begin
        valid_q[alloc_ptr_q] <= 1'b1;
        done_q[alloc_ptr_q]  <= 1'b0;
        alloc_ptr_q          <= alloc_ptr_q + 1'b1;
      end
      // returns only land on ids already in flight and never on the one being allocated
      if (ret_v_i)
        done_q[ret_id] <= 1'b1;
      if (resp_fire)
      begin
        valid_q[rel_ptr_q] <= 1'b0;
        done_q[rel_ptr_q]  <= 1'b0;
        rel_ptr_q          <= rel_ptr_q + 1'b1;
      end
    end
  end

  // headers and return data
  always_ff @(posedge clk_i)
  begin
    if (alloc_fire)
      hdr_q[alloc_ptr_q] <= alloc_hdr_i;
    if (ret_v_i)
      data_q[ret_id] <= ret_i.is_load ? ret_i.data : '0;
  end

endmodule

// ==== src/inbound_request_adapter.sv ====
`timescale 1ns/1ps
`include "mesh_bridge_params.svh"

module inbound_request_adapter
  (
    input  mesh_bridge_pkg::net_in_t  net_in_i,
    input  logic                      net_in_v_i,
    output logic                      net_in_yumi_o,
    output mesh_bridge_pkg::mem_msg_t io_cmd_o,
    output logic                      io_cmd_v_o,
    input  logic                      io_cmd_yumi_i,
    input  mesh_bridge_pkg::mem_msg_t io_resp_i,
    input  logic                      io_resp_v_i,
    output logic [`MB_DATA_W-1:0]     returning_data_o,
    output logic                      returning_v_o
  );

  import mesh_bridge_pkg::*;

  logic [`MB_PADDR_W-1:0] in_offset;

  assign in_offset = {{(`MB_PADDR_W - 12){1'b0}}, net_in_i.addr};

  // network request to processor command
  always_comb
  begin
    io_cmd_o.header.msg_type = net_in_i.we ? e_uc_wr : e_uc_rd;
    io_cmd_o.header.size     = e_size_4;
    if (net_in_i.dev == 4'd1)
      io_cmd_o.header.addr = `MB_CLINT_BASE + in_offset;
    else
      io_cmd_o.header.addr = `MB_CFG_BASE + in_offset;
    io_cmd_o.data = net_in_i.data;
  end

  assign io_cmd_v_o    = net_in_v_i;
  assign net_in_yumi_o = io_cmd_yumi_i;

  // reply trimmed to the requested size
  always_comb
  begin
    case (io_resp_i.header.size)
      e_size_1: returning_data_o = {{(`MB_DATA_W - 8){1'b0}}, io_resp_i.data[7:0]};
      e_size_2: returning_data_o = {{(`MB_DATA_W - 16){1'b0}}, io_resp_i.data[15:0]};
      default:  returning_data_o = io_resp_i.data;
    endcase
  end

  assign returning_v_o = io_resp_v_i;

endmodule

// ==== src/mesh_bridge_top.sv ====
`timescale 1ns/1ps
`include "mesh_bridge_params.svh"

module mesh_bridge_top
  (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic [`MB_CORD_W-1:0]     my_x_i,
    input  logic [`MB_CORD_W-1:0]     my_y_i,
    // processor uncached port
    input  mesh_bridge_pkg::mem_msg_t io_cmd_i,
    input  logic                      io_cmd_v_i,
    output logic                      io_cmd_ready_o,
    output mesh_bridge_pkg::mem_msg_t io_resp_o,
    output logic                      io_resp_v_o,
    input  logic                      io_resp_yumi_i,
    // commands into the processor
    output mesh_bridge_pkg::mem_msg_t io_cmd_o,
    output logic                      io_cmd_v_o,
    input  logic                      io_cmd_yumi_i,
    input  mesh_bridge_pkg::mem_msg_t io_resp_i,
    input  logic                      io_resp_v_i,
    // mesh side
    output mesh_bridge_pkg::net_req_t net_req_o,
    output logic                      net_req_v_o,
    input  logic                      net_req_ready_i,
    input  mesh_bridge_pkg::net_ret_t net_ret_i,
    input  logic                      net_ret_v_i,
    input  mesh_bridge_pkg::net_in_t  net_in_i,
    input  logic                      net_in_v_i,
    output logic                      net_in_yumi_o,
    output logic [`MB_DATA_W-1:0]     returning_data_o,
    output logic                      returning_v_o
  );

  import mesh_bridge_pkg::*;

  mem_msg_t            head;
  logic                head_v;
  logic                alloc_v;
  logic [`MB_ID_W-1:0] alloc_id;
  logic                send;

  ////////////////////////////////////////////////////////////
  // outbound commands
  ////////////////////////////////////////////////////////////
  cmd_header_fifo u_fifo
    (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .data_i   (io_cmd_i),
      .v_i      (io_cmd_v_i),
      .ready_o  (io_cmd_ready_o),
      .data_o   (head),
      .v_o      (head_v),
      .yumi_i   (send)
    );

  // a command leaves only with a free id and a ready network
  assign send        = head_v & alloc_v & net_req_ready_i;
  assign net_req_v_o = send;

  outbound_packet_builder u_builder
    (
      .cmd_i  (head.header),
      .data_i (head.data),
      .id_i   (alloc_id),
      .my_x_i (my_x_i),
      .my_y_i (my_y_i),
      .pkt_o  (net_req_o)
    );

  return_reorder_buffer u_rob
    (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .alloc_v_o    (alloc_v),
      .alloc_id_o   (alloc_id),
      .alloc_yumi_i (send),
      .alloc_hdr_i  (head.header),
      .ret_i        (net_ret_i),
      .ret_v_i      (net_ret_v_i),
      .resp_o       (io_resp_o),
      .resp_v_o     (io_resp_v_o),
      .resp_yumi_i  (io_resp_yumi_i)
    );

  ////////////////////////////////////////////////////////////
  // inbound requests
  ////////////////////////////////////////////////////////////
  inbound_request_adapter u_inbound
    (
      .net_in_i         (net_in_i),
      .net_in_v_i       (net_in_v_i),
      .net_in_yumi_o    (net_in_yumi_o),
      .io_cmd_o         (io_cmd_o),
      .io_cmd_v_o       (io_cmd_v_o),
      .io_cmd_yumi_i    (io_cmd_yumi_i),
      .io_resp_i        (io_resp_i),
      .io_resp_v_i      (io_resp_v_i),
      .returning_data_o (returning_data_o),
      .returning_v_o    (returning_v_o)
    );

endmodule

// ==== verification/mesh_bridge_tb.sv ====
`timescale 1ns/1ps
`include "mesh_bridge_params.svh"

module mesh_bridge_tb;

  import mesh_bridge_pkg::*;

  localparam int NUM_CMDS   = 400;
  localparam int CYCLES_PER = 40;
  localparam int CLK_PERIOD = 100;

  logic                  clk_i;
  logic                  arst_n_i;
  logic [`MB_CORD_W-1:0] my_x_i;
  logic [`MB_CORD_W-1:0] my_y_i;
  mem_msg_t              io_cmd_i;
  logic                  io_cmd_v_i;
  logic                  io_cmd_ready_o;
  mem_msg_t              io_resp_o;
  logic                  io_resp_v_o;
  logic                  io_resp_yumi_i;
  mem_msg_t              io_cmd_o;
  logic                  io_cmd_v_o;
  logic                  io_cmd_yumi_i;
  mem_msg_t              io_resp_i;
  logic                  io_resp_v_i;
  net_req_t              net_req_o;
  logic                  net_req_v_o;
  logic                  net_req_ready_i;
  net_ret_t              net_ret_i;
  logic                  net_ret_v_i;
  net_in_t               net_in_i;
  logic                  net_in_v_i;
  logic                  net_in_yumi_o;
  logic [`MB_DATA_W-1:0] returning_data_o;
  logic                  returning_v_o;

  integer   seed = 66059;
  int       errors;
  int       checks;
  int       accepted;
  int       sent;
  int       responded;
  logic     cmd_taken;
  logic     hold_v;
  mem_msg_t hold_resp;
  mem_msg_t queued_q [$];
  mem_msg_t expect_q [$];
  net_ret_t pend_ret_q [$];
  int       pend_wait_q [$];

  mesh_bridge_top u_dut
    (
      .clk_i            (clk_i),
      .arst_n_i         (arst_n_i),
      .my_x_i           (my_x_i),
      .my_y_i           (my_y_i),
      .io_cmd_i         (io_cmd_i),
      .io_cmd_v_i       (io_cmd_v_i),
      .io_cmd_ready_o   (io_cmd_ready_o),
      .io_resp_o        (io_resp_o),
      .io_resp_v_o      (io_resp_v_o),
      .io_resp_yumi_i   (io_resp_yumi_i),
      .io_cmd_o         (io_cmd_o),
      .io_cmd_v_o       (io_cmd_v_o),
      .io_cmd_yumi_i    (io_cmd_yumi_i),
      .io_resp_i        (io_resp_i),
      .io_resp_v_i      (io_resp_v_i),
      .net_req_o        (net_req_o),
      .net_req_v_o      (net_req_v_o),
      .net_req_ready_i  (net_req_ready_i),
      .net_ret_i        (net_ret_i),
      .net_ret_v_i      (net_ret_v_i),
      .net_in_i         (net_in_i),
      .net_in_v_i       (net_in_v_i),
      .net_in_yumi_o    (net_in_yumi_o),
      .returning_data_o (returning_data_o),
      .returning_v_o    (returning_v_o)
    );

  initial
    clk_i = 1'b0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // random helpers and reference model
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  function automatic logic chance(int pct);
    chance = (rand_word() % 32'd100) < 32'(pct);
  endfunction

  function automatic mem_msg_t random_command();
    mem_msg_t    cmd;
    logic [31:0] r;
    r = rand_word();
    cmd.header.msg_type = r[0] ? e_uc_wr : e_uc_rd;
    case (r[2:1])
      2'd0:    cmd.header.size = e_size_1;
      2'd1:    cmd.header.size = e_size_2;
      default: cmd.header.size = e_size_4;
    endcase
    cmd.header.addr = rand_word();
    // naturally aligned accesses only
    if (cmd.header.size == e_size_2)
      cmd.header.addr[0] = 1'b0;
    if (cmd.header.size == e_size_4)
      cmd.header.addr[1:0] = 2'b00;
    cmd.data = rand_word();
    random_command = cmd;
  endfunction

  // request packet built from the address layout and mask rules
  function automatic net_req_t expected_packet(mem_msg_t cmd, logic [`MB_ID_W-1:0] id);
    net_req_t    p;
    logic [31:0] a;
    logic [1:0]  size_code;
    a = cmd.header.addr;
    size_code = cmd.header.size;
    p = '0;
    p.reg_id = {{(`MB_REG_ID_W - `MB_ID_W){1'b0}}, id};
    p.src_x = my_x_i;
    p.src_y = my_y_i;
    p.epa = a[17:2];
    if (a[31])
    begin
      p.dst_y = a[29:24];
      p.dst_x = a[23:18];
    end
    else
    begin
      p.dst_x = '0;
      p.dst_y = my_y_i - 6'd1;
    end
    if (cmd.header.msg_type == e_uc_wr)
    begin
      p.op = e_remote_store;
      p.payload = cmd.data;
      case (cmd.header.size)
        e_size_1: p.mask = 4'b0001 << a[1:0];
        e_size_2: p.mask = 4'b0011 << a[1:0];
        default:  p.mask = 4'b1111;
      endcase
    end
    else
    begin
      p.op = e_remote_load;
      p.mask = 4'b0000;
      p.payload = {28'd0, size_code, a[1:0]};
    end
    expected_packet = p;
  endfunction

  // load data the network model hands back
  function automatic logic [31:0] load_data(net_req_t p);
    load_data = {p.epa, p.dst_x, p.dst_y, p.payload[3:0]} ^ 32'h5a3c_96e1;
  endfunction

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic note_error(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  ////////////////////////////////////////////////////////////
  // per cycle stimulus
  ////////////////////////////////////////////////////////////
  task automatic drive_inputs();
    int          idx;
    int          i;
    logic [31:0] r;
    // command held steady until taken
    if (!io_cmd_v_i || cmd_taken)
    begin
      io_cmd_v_i = (accepted < NUM_CMDS) && chance(80);
      io_cmd_i   = random_command();
    end
    cmd_taken       = 1'b0;
    net_req_ready_i = chance(75);
    io_resp_yumi_i  = chance(60);

    // network returns in shuffled order
    net_ret_v_i = 1'b0;
    net_ret_i   = '0;
    for (i = 0; i < pend_wait_q.size(); i++)
      pend_wait_q[i] = pend_wait_q[i] - 1;
    if (pend_ret_q.size() > 0 && chance(70))
    begin
      idx = int'(rand_word() % 32'(pend_ret_q.size()));
      if (pend_wait_q[idx] <= 0)
      begin
        net_ret_i   = pend_ret_q[idx];
        net_ret_v_i = 1'b1;
        pend_ret_q.delete(idx);
        pend_wait_q.delete(idx);
      end
    end

    // inbound side with dev 1 picked often
    r = rand_word();
    net_in_i.we   = r[0];
    net_in_i.dev  = (r[2:1] == 2'd0) ? 4'd1 : r[7:4];
    net_in_i.addr = r[19:8];
    net_in_i.data = rand_word();
    net_in_v_i    = chance(50);
    io_cmd_yumi_i = chance(50);
    io_resp_i.header.msg_type = e_uc_rd;
    case (r[21:20])
      2'd0:    io_resp_i.header.size = e_size_1;
      2'd1:    io_resp_i.header.size = e_size_2;
      default: io_resp_i.header.size = e_size_4;
    endcase
    io_resp_i.header.addr = rand_word();
    io_resp_i.data        = rand_word();
    io_resp_v_i           = chance(50);
  endtask

  task automatic sample_outputs();
    mem_msg_t                cmd;
    mem_msg_t                exp_resp;
    mem_msg_t                exp_cmd;
    net_req_t                exp_pkt;
    net_ret_t                ret;
    logic                    exp_send;
    logic                    exp_resp_v;
    logic [`MB_REG_ID_W-1:0] head_id;
    logic [31:0]             base;
    logic [31:0]             exp_ret;
    int                      k;
    exp_send = (queued_q.size() > 0) && (expect_q.size() < `MB_MAX_OUT) && net_req_ready_i;

    // oldest command is presented once its return has been taken in
    head_id = '0;
    head_id[`MB_ID_W-1:0] = responded[`MB_ID_W-1:0];
    exp_resp_v = (expect_q.size() > 0);
    if (net_ret_v_i && net_ret_i.reg_id == head_id)
      exp_resp_v = 1'b0;
    for (k = 0; k < pend_ret_q.size(); k++)
    begin
      if (pend_ret_q[k].reg_id == head_id)
        exp_resp_v = 1'b0;
    end

    check_value("io_cmd_ready_o", 128'(queued_q.size() < `MB_FIFO_DEPTH), 128'(io_cmd_ready_o));
    check_value("net_req_v_o", 128'(exp_send), 128'(net_req_v_o));
    check_value("io_resp_v_o", 128'(exp_resp_v), 128'(io_resp_v_o));

    if (net_req_v_o)
    begin
      if (queued_q.size() == 0)
        note_error("request sent while no command was queued");
      else
      begin
        cmd = queued_q.pop_front();
        exp_pkt = expected_packet(cmd, sent[`MB_ID_W-1:0]);
        check_value("net_req_o", 128'(exp_pkt), 128'(net_req_o));
        exp_resp.header = cmd.header;
        exp_resp.data   = (cmd.header.msg_type == e_uc_rd) ? load_data(exp_pkt) : 32'd0;
        expect_q.push_back(exp_resp);
        // network model keeps what it received
        ret.reg_id  = net_req_o.reg_id;
        ret.is_load = (net_req_o.op == e_remote_load);
        ret.data    = load_data(net_req_o);
        pend_ret_q.push_back(ret);
        pend_wait_q.push_back(1 + int'(rand_word() % 32'd24));
        sent++;
      end
    end

    if (io_cmd_v_i && io_cmd_ready_o)
    begin
      queued_q.push_back(io_cmd_i);
      accepted++;
      cmd_taken = 1'b1;
    end

    // a stalled response must not move
    if (hold_v)
      check_value("io_resp_o", 128'(hold_resp), 128'(io_resp_o));
    if (io_resp_v_o && io_resp_yumi_i)
    begin
      if (expect_q.size() == 0)
        note_error("response seen with no outstanding command");
      else
      begin
        exp_resp = expect_q.pop_front();
        check_value("io_resp_o", 128'(exp_resp), 128'(io_resp_o));
        responded++;
      end
    end
    hold_v    = io_resp_v_o && !io_resp_yumi_i;
    hold_resp = io_resp_o;

    // inbound translation
    exp_cmd.header.msg_type = net_in_i.we ? e_uc_wr : e_uc_rd;
    exp_cmd.header.size     = e_size_4;
    base = (net_in_i.dev == 4'd1) ? `MB_CLINT_BASE : `MB_CFG_BASE;
    exp_cmd.header.addr = base + {20'd0, net_in_i.addr};
    exp_cmd.data        = net_in_i.data;
    check_value("io_cmd_o", 128'(exp_cmd), 128'(io_cmd_o));
    check_value("io_cmd_v_o", 128'(net_in_v_i), 128'(io_cmd_v_o));
    check_value("net_in_yumi_o", 128'(io_cmd_yumi_i), 128'(net_in_yumi_o));

    // reply zero extended by size
    case (io_resp_i.header.size)
      e_size_1: exp_ret = {24'd0, io_resp_i.data[7:0]};
      e_size_2: exp_ret = {16'd0, io_resp_i.data[15:0]};
      default:  exp_ret = io_resp_i.data;
    endcase
    check_value("returning_data_o", 128'(exp_ret), 128'(returning_data_o));
    check_value("returning_v_o", 128'(io_resp_v_i), 128'(returning_v_o));
  endtask

  task automatic run_cycle();
    @(posedge clk_i);
    #5;
    drive_inputs();
    @(negedge clk_i);
    sample_outputs();
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////
  initial
  begin
    errors          = 0;
    checks          = 0;
    accepted        = 0;
    sent            = 0;
    responded       = 0;
    cmd_taken       = 1'b0;
    hold_v          = 1'b0;
    hold_resp       = '0;
    my_x_i          = 6'd3;
    my_y_i          = 6'd5;
    io_cmd_i        = '0;
    io_cmd_v_i      = 1'b0;
    io_resp_yumi_i  = 1'b0;
    io_cmd_yumi_i   = 1'b0;
    io_resp_i       = '0;
    io_resp_v_i     = 1'b0;
    net_req_ready_i = 1'b0;
    net_ret_i       = '0;
    net_ret_v_i     = 1'b0;
    net_in_i        = '0;
    net_in_v_i      = 1'b0;
    arst_n_i        = 1'b0;
    repeat (8) @(posedge clk_i);
    #5;
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_value("net_req_v_o", 128'(1'b0), 128'(net_req_v_o));
    check_value("io_resp_v_o", 128'(1'b0), 128'(io_resp_v_o));
    check_value("io_cmd_ready_o", 128'(1'b1), 128'(io_cmd_ready_o));

    while (responded < NUM_CMDS)
      run_cycle();
    // idle tail catches stray requests or responses
    repeat (20)
      run_cycle();

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  initial
  begin
    #(NUM_CMDS * CYCLES_PER * CLK_PERIOD);
    $display("Timeout: the run did not finish in time, %0d of %0d responses seen",
             responded, NUM_CMDS);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+src
src/mesh_bridge_pkg.sv
src/cmd_header_fifo.sv
src/outbound_packet_builder.sv
src/return_reorder_buffer.sv
src/inbound_request_adapter.sv
src/mesh_bridge_top.sv
verification/mesh_bridge_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the mesh bridge testbench with Verilator
set -o pipefail

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module mesh_bridge_tb \
  --Mdir obj_dir -o mesh_bridge_sim 2>&1 | tee "$LOG" \
  && ./obj_dir/mesh_bridge_sim 2>&1 | tee -a "$LOG" \
  || { echo "build or simulation did not complete"; exit 1; }

grep -q "Testbench failed" "$LOG" && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
